//--- hdl/vipu_pkg.sv
/*
 * Shared types and constants of the SIMD integer unit.
 * Holds the operation and element-width encodings, the register map
 * of the Wishbone block and the lane widths of the integer unit.
 */
`default_nettype none

package vipu_pkg;

  localparam int unsigned ELEN  = 32;
  localparam int unsigned ELENB = ELEN / 8;

  typedef logic [ELEN-1:0]  word_t;
  typedef logic [ELENB-1:0] carry_t;
  typedef logic [2:0]       reg_idx_t;

  typedef enum logic [3:0] {
    VADD, VSUB, VADC, VAND, VOR, VXOR,
    VMIN, VMAX, VMINU, VMAXU, VMUL, VMACC
  } op_e;

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } sew_e;

  typedef enum logic [1:0] {IDLE, ACK, HOLD} wb_state_e;

  // Word indices from address bits 4:2
  localparam reg_idx_t REG_S1     = 3'd0;
  localparam reg_idx_t REG_S2     = 3'd1;
  localparam reg_idx_t REG_D      = 3'd2;
  localparam reg_idx_t REG_CTRL   = 3'd3;
  localparam reg_idx_t REG_RESULT = 3'd4;
  localparam reg_idx_t REG_STATUS = 3'd5;

  // CTRL fields
  localparam int unsigned CTRL_OP_LSB    = 0;
  localparam int unsigned CTRL_OP_MSB    = 3;
  localparam int unsigned CTRL_SEW_LSB   = 4;
  localparam int unsigned CTRL_SEW_MSB   = 5;
  localparam int unsigned CTRL_CARRY_LSB = 8;
  localparam int unsigned CTRL_CARRY_MSB = 11;

  // Lane geometry
  localparam int unsigned LANE8_W    = 8;
  localparam int unsigned LANE16_W   = 16;
  localparam int unsigned LANE32_W   = 32;
  localparam int unsigned LANE_OPNDS = 3;

endpackage

`default_nettype wire

//--- hdl/vipu_if.sv
/*
 * One operation request and its result, passed from the register
 * block (req side) to the integer unit (rsp side). No ready signal.
 */
`timescale 1ns/1ns
`default_nettype none

interface vipu_if import vipu_pkg::*; ();

  logic   valid;
  op_e    operation;
  sew_e   sew;
  carry_t carry;
  word_t  op_s1;
  word_t  op_s2;
  word_t  op_d;

  logic   result_valid;
  word_t  result;

  modport req (
    output valid, operation, sew, carry, op_s1, op_s2, op_d,
    input  result_valid, result
  );

  modport rsp (
    input  valid, operation, sew, carry, op_s1, op_s2, op_d,
    output result_valid, result
  );

endinterface

`default_nettype wire

//--- hdl/vipu_simd_lane.sv
/*
 * Single SIMD lane of configurable width. Computes the selected
 * operation on one element and registers the result.
 */
`timescale 1ns/1ns
`default_nettype none

module vipu_simd_lane import vipu_pkg::*; #(
  parameter int unsigned Width = 8
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  op_e              operation_i,
  input  logic [Width-1:0] op_s1_i,
  input  logic [Width-1:0] op_s2_i,
  input  logic [Width-1:0] op_d_i,
  input  logic             is_signed_i,
  input  logic             carry_i,
  output logic [Width-1:0] result_o
);

  logic [Width-1:0] product;
  logic [Width-1:0] res_d;
  logic [Width-1:0] res_q;
  logic             s1_lt_s2;

  // Low half only
  assign product = op_s1_i * op_s2_i;

  assign s1_lt_s2 = is_signed_i ? ($signed(op_s1_i) < $signed(op_s2_i))
                                : (op_s1_i < op_s2_i);

  ////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////

  always_comb begin : lane_alu
    case (operation_i)
      VADD: begin
        res_d = op_s1_i + op_s2_i;
      end
      VSUB: begin
        res_d = op_s1_i - op_s2_i;
      end
      VADC: begin
        res_d = op_s1_i + op_s2_i + Width'(carry_i);
      end
      VAND: begin
        res_d = op_s1_i & op_s2_i;
      end
      VOR: begin
        res_d = op_s1_i | op_s2_i;
      end
      VXOR: begin
        res_d = op_s1_i ^ op_s2_i;
      end
      VMIN, VMINU: begin
        res_d = s1_lt_s2 ? op_s1_i : op_s2_i;
      end
      VMAX, VMAXU: begin
        res_d = s1_lt_s2 ? op_s2_i : op_s1_i;
      end
      VMUL: begin
        res_d = product;
      end
      VMACC: begin
        res_d = op_d_i + product;
      end
      default: begin
        res_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : lane_reg
    if (!rst_n_i) begin
      res_q <= '0;
    end else begin
      res_q <= res_d;
    end
  end

  assign result_o = res_q;

endmodule

`default_nettype wire

//--- hdl/vipu_ipu.sv
/*
 * SIMD integer unit. Spreads the operand word over four lanes
 * (8, 8, 16, 32 bits), registers the lane results and gathers them
 * back by the element width of the operation in flight.
 */
`timescale 1ns/1ns
`default_nettype none

module vipu_ipu import vipu_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  vipu_if.rsp  ipu
);

  logic                is_signed;
  word_t               opnd       [LANE_OPNDS];
  logic [LANE8_W-1:0]  lane8_op   [2][LANE_OPNDS];
  logic [LANE16_W-1:0] lane16_op  [LANE_OPNDS];
  logic [LANE32_W-1:0] lane32_op  [LANE_OPNDS];
  logic [1:0]          lane8_carry;
  logic                lane16_carry;
  logic                lane32_carry;
  logic [LANE8_W-1:0]  lane8_res  [2];
  logic [LANE16_W-1:0] lane16_res;
  logic [LANE32_W-1:0] lane32_res;
  logic                valid_q;
  sew_e                sew_q;

  assign is_signed = ipu.operation inside {VMIN, VMAX};

  assign opnd[0] = ipu.op_s1;
  assign opnd[1] = ipu.op_s2;
  assign opnd[2] = ipu.op_d;

  ////////////////////////////////////////
  // Distributor
  ////////////////////////////////////////

  always_comb begin : distributor
    lane8_op     = '{default: '0};
    lane16_op    = '{default: '0};
    lane32_op    = '{default: '0};
    lane8_carry  = '0;
    lane16_carry = 1'b0;
    lane32_carry = 1'b0;

    if (ipu.sew == EW_8) begin
      for (int i = 0; i < LANE_OPNDS; i++) begin
        lane8_op[0][i] = opnd[i][7:0];
        lane8_op[1][i] = opnd[i][15:8];
        lane16_op[i]   = {{(LANE16_W-8){is_signed & opnd[i][23]}}, opnd[i][23:16]};
        lane32_op[i]   = {{(LANE32_W-8){is_signed & opnd[i][31]}}, opnd[i][31:24]};
      end
      lane8_carry  = ipu.carry[1:0];
      lane16_carry = ipu.carry[2];
      lane32_carry = ipu.carry[3];
    end else if (ipu.sew == EW_16) begin
      for (int i = 0; i < LANE_OPNDS; i++) begin
        lane16_op[i] = opnd[i][15:0];
        lane32_op[i] = {{(LANE32_W-16){is_signed & opnd[i][31]}}, opnd[i][31:16]};
      end
      lane16_carry = ipu.carry[0];
      lane32_carry = ipu.carry[1];
    end else begin
      // Code 3 lands here as well
      for (int i = 0; i < LANE_OPNDS; i++) begin
        lane32_op[i] = opnd[i];
      end
      lane32_carry = ipu.carry[0];
    end
  end

  ////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////

  for (genvar g = 0; g < 2; g++) begin : gen_lane8
    vipu_simd_lane #(
      .Width (LANE8_W)
    ) u_lane (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .operation_i (ipu.operation),
      .op_s1_i     (lane8_op[g][0]),
      .op_s2_i     (lane8_op[g][1]),
      .op_d_i      (lane8_op[g][2]),
      .is_signed_i (is_signed),
      .carry_i     (lane8_carry[g]),
      .result_o    (lane8_res[g])
    );
  end

  vipu_simd_lane #(
    .Width (LANE16_W)
  ) u_lane16 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operation_i (ipu.operation),
    .op_s1_i     (lane16_op[0]),
    .op_s2_i     (lane16_op[1]),
    .op_d_i      (lane16_op[2]),
    .is_signed_i (is_signed),
    .carry_i     (lane16_carry),
    .result_o    (lane16_res)
  );

  vipu_simd_lane #(
    .Width (LANE32_W)
  ) u_lane32 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operation_i (ipu.operation),
    .op_s1_i     (lane32_op[0]),
    .op_s2_i     (lane32_op[1]),
    .op_d_i      (lane32_op[2]),
    .is_signed_i (is_signed),
    .carry_i     (lane32_carry),
    .result_o    (lane32_res)
  );

  // Valid and SEW travel alongside the lane registers
  always_ff @(posedge clk_i or negedge rst_n_i) begin : pipe_ctrl
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      sew_q   <= EW_8;
    end else begin
      valid_q <= ipu.valid;
      sew_q   <= ipu.sew;
    end
  end

  assign ipu.result_valid = valid_q;

  ////////////////////////////////////////
  // Collector
  ////////////////////////////////////////

  always_comb begin : collector
    if (sew_q == EW_8) begin
      ipu.result = {lane32_res[7:0], lane16_res[7:0], lane8_res[1], lane8_res[0]};
    end else if (sew_q == EW_16) begin
      ipu.result = {lane32_res[15:0], lane16_res};
    end else begin
      ipu.result = lane32_res;
    end
  end

endmodule

`default_nettype wire

//--- hdl/vipu_wb_regs.sv
/*
 * Wishbone classic slave with operand, control, result and status
 * registers. A control write launches one operation on the unit;
 * result reads wait in HOLD while the operation is in flight.
 */
`timescale 1ns/1ns
`default_nettype none

module vipu_wb_regs import vipu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       wb_cyc_i,
  input  logic       wb_stb_i,
  input  logic       wb_we_i,
  input  logic [4:0] wb_adr_i,
  input  word_t      wb_dat_i,
  output word_t      wb_dat_o,
  output logic       wb_ack_o,
  vipu_if.req        ipu
);

  wb_state_e state_q;
  reg_idx_t  idx;
  logic      access;
  logic      result_read;
  logic      wr_en;
  logic      ack_q;
  logic      busy_q;
  logic      valid_q;
  word_t     s1_q;
  word_t     s2_q;
  word_t     d_q;
  word_t     ctrl_q;
  word_t     result_q;
  word_t     rdata;
  word_t     rdata_q;

  assign idx         = wb_adr_i[4:2];
  assign access      = wb_cyc_i & wb_stb_i;
  assign result_read = !wb_we_i && (idx == REG_RESULT);
  assign wr_en       = (state_q == IDLE) && access && wb_we_i;

  always_comb begin : read_mux
    case (idx)
      REG_S1:     rdata = s1_q;
      REG_S2:     rdata = s2_q;
      REG_D:      rdata = d_q;
      REG_CTRL:   rdata = ctrl_q;
      REG_RESULT: rdata = result_q;
      REG_STATUS: rdata = {{(ELEN-1){1'b0}}, busy_q};
      default:    rdata = '0;
    endcase
  end

  ////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin : bus_fsm
    if (!rst_n_i) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      ack_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (access) begin
            if (result_read && busy_q) begin
              state_q <= HOLD;
            end else begin
              state_q <= ACK;
              ack_q   <= 1'b1;
              rdata_q <= rdata;
            end
          end
        end
        HOLD: begin
          // Master gave up the cycle
          if (!access) begin
            state_q <= IDLE;
          end else if (!busy_q) begin
            state_q <= ACK;
            ack_q   <= 1'b1;
            rdata_q <= rdata;
          end
        end
        ACK: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Registers and launch
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin : reg_file
    if (!rst_n_i) begin
      s1_q     <= '0;
      s2_q     <= '0;
      d_q      <= '0;
      ctrl_q   <= '0;
      result_q <= '0;
      busy_q   <= 1'b0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (ipu.result_valid) begin
        result_q <= ipu.result;
        busy_q   <= 1'b0;
      end
      if (wr_en) begin
        case (idx)
          REG_S1: s1_q <= wb_dat_i;
          REG_S2: s2_q <= wb_dat_i;
          REG_D:  d_q  <= wb_dat_i;
          REG_CTRL: begin
            ctrl_q  <= wb_dat_i;
            valid_q <= 1'b1;
            busy_q  <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = rdata_q;

  // Request fields come from the stored control word
  assign ipu.valid     = valid_q;
  assign ipu.operation = op_e'(ctrl_q[CTRL_OP_MSB:CTRL_OP_LSB]);
  assign ipu.sew       = sew_e'(ctrl_q[CTRL_SEW_MSB:CTRL_SEW_LSB]);
  assign ipu.carry     = ctrl_q[CTRL_CARRY_MSB:CTRL_CARRY_LSB];
  assign ipu.op_s1     = s1_q;
  assign ipu.op_s2     = s2_q;
  assign ipu.op_d      = d_q;

endmodule

`default_nettype wire

//--- hdl/vipu_top.sv
/*
 * Top level of the SIMD integer unit with a Wishbone classic slave
 * port. Joins the register block and the integer unit.
 */
`timescale 1ns/1ns
`default_nettype none

module vipu_top import vipu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       wb_cyc_i,
  input  logic       wb_stb_i,
  input  logic       wb_we_i,
  input  logic [4:0] wb_adr_i,
  input  word_t      wb_dat_i,
  output word_t      wb_dat_o,
  output logic       wb_ack_o
);

  // Request and result path
  vipu_if ipu_bus ();

  vipu_wb_regs u_regs (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .ipu      (ipu_bus.req)
  );

  vipu_ipu u_ipu (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .ipu     (ipu_bus.rsp)
  );

endmodule

`default_nettype wire

//--- tb/vipu_props.sv
/*
 * Assertions on the Wishbone handshake and the launch timing of the
 * register block. Bound into every vipu_wb_regs instance.
 */
`timescale 1ns/1ns
`default_nettype none

module vipu_props import vipu_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input logic      wb_cyc_i,
  input logic      wb_stb_i,
  input logic      wb_ack_o,
  input wb_state_e state_i,
  input logic      valid_i,
  input logic      result_valid_i
);

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("acknowledge held for more than one cycle");

  ack_needs_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
    else $error("acknowledge without an active strobe");

  result_after_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |=> result_valid_i)
    else $error("result valid did not follow the request");

  // A held read is released on the edge after the result was captured
  held_read_after_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(state_i) == HOLD && state_i == ACK |-> $past(result_valid_i, 2))
    else $error("held result read released before the result arrived");

endmodule

bind vipu_wb_regs vipu_props u_props (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .wb_cyc_i       (wb_cyc_i),
  .wb_stb_i       (wb_stb_i),
  .wb_ack_o       (wb_ack_o),
  .state_i        (state_q),
  .valid_i        (valid_q),
  .result_valid_i (ipu.result_valid)
);

`default_nettype wire

//--- tb/vipu_checker.sv
/*
 * Watches Wishbone reads of the result register and compares the
 * returned data with the expected value given by the testbench.
 * Counts checked results and mismatches.
 */
`timescale 1ns/1ns
`default_nettype none

module vipu_checker import vipu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       cyc_i,
  input  logic       stb_i,
  input  logic       we_i,
  input  logic [4:0] adr_i,
  input  word_t      rdata_i,
  input  logic       ack_i,
  input  word_t      expected_i,
  output int         checked_o,
  output int         errors_o
);

  logic read_pending;

  ////////////////////////////////////////
  // Result read monitor
  ////////////////////////////////////////

  // Acknowledge seen here answers the request sampled one edge earlier
  always @(posedge clk_i or negedge rst_n_i) begin : monitor
    if (!rst_n_i) begin
      read_pending = 1'b0;
      checked_o    = 0;
      errors_o     = 0;
    end else begin
      if (ack_i && read_pending) begin
        checked_o++;
        if (rdata_i !== expected_i) begin
          errors_o++;
          $display("Mismatch at %0t ns: wb_dat_o expected %08h, actual %08h",
                   $time, expected_i, rdata_i);
        end
      end
      read_pending = cyc_i && stb_i && !we_i && (adr_i[4:2] == REG_RESULT);
    end
  end

endmodule

`default_nettype wire

//--- tb/vipu_tb.sv
/*
 * Testbench for the SIMD integer unit. Reads one case per line from
 * the cases file, drives it through the Wishbone port and hands the
 * expected result to the checker.
 */
`timescale 1ns/1ns
`default_nettype none

module vipu_tb import vipu_pkg::*; ();

  localparam int unsigned ACK_TIMEOUT = 20;

  logic       clk_i;
  logic       rst_n_i;
  logic       wb_cyc_i;
  logic       wb_stb_i;
  logic       wb_we_i;
  logic [4:0] wb_adr_i;
  word_t      wb_dat_i;
  word_t      wb_dat_o;
  logic       wb_ack_o;
  word_t      expected;
  int         checked;
  int         mismatches;
  int         other_errors;
  int         num_cases;

  vipu_top dut (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  vipu_checker u_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cyc_i      (wb_cyc_i),
    .stb_i      (wb_stb_i),
    .we_i       (wb_we_i),
    .adr_i      (wb_adr_i),
    .rdata_i    (wb_dat_o),
    .ack_i      (wb_ack_o),
    .expected_i (expected),
    .checked_o  (checked),
    .errors_o   (mismatches)
  );

  always #2 clk_i = ~clk_i;

  // One single access; called right after a falling edge
  task automatic bus_access(input logic we, input reg_idx_t idx, input word_t wdata,
                            input string reg_name);
    int waited;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {idx, 2'b00};
    wb_dat_i = wdata;
    waited   = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!wb_ack_o && waited < ACK_TIMEOUT);
    if (!wb_ack_o) begin
      $display("Error at %0t ns: no acknowledge from register %s within %0d cycles",
               $time, reg_name, ACK_TIMEOUT);
      other_errors++;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic run_case(input word_t op, input word_t sew, input word_t carry,
                          input word_t s1, input word_t s2, input word_t d,
                          input word_t exp_res, input word_t mode);
    word_t ctrl;
    ctrl = '0;
    ctrl[CTRL_OP_MSB:CTRL_OP_LSB]       = op[3:0];
    ctrl[CTRL_SEW_MSB:CTRL_SEW_LSB]     = sew[1:0];
    ctrl[CTRL_CARRY_MSB:CTRL_CARRY_LSB] = carry[3:0];
    bus_access(1'b1, REG_S1, s1, "S1");
    bus_access(1'b1, REG_S2, s2, "S2");
    bus_access(1'b1, REG_D, d, "D");
    bus_access(1'b1, REG_CTRL, ctrl, "CTRL");
    // Operands changed while the operation is in flight
    if (mode[0]) begin
      bus_access(1'b1, REG_S1, ~s1, "S1");
      bus_access(1'b1, REG_S2, ~s2, "S2");
      bus_access(1'b1, REG_D, ~d, "D");
    end
    expected = exp_res;
    bus_access(1'b0, REG_RESULT, '0, "RESULT");
  endtask

  initial begin : main
    int    fd;
    int    n;
    int    idle;
    string line;
    word_t op;
    word_t sew;
    word_t carry;
    word_t s1;
    word_t s2;
    word_t d;
    word_t exp_res;
    word_t mode;

    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    expected     = '0;
    other_errors = 0;
    num_cases    = 0;
    void'($urandom(20));

    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    fd = $fopen("tb/vipu_cases.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open the cases file tb/vipu_cases.txt");
      other_errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() == 0 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                    op, sew, carry, s1, s2, d, exp_res, mode);
        if (n != 8) begin
          continue;
        end
        run_case(op, sew, carry, s1, s2, d, exp_res, mode);
        num_cases++;
        idle = $urandom_range(3, 0);
        repeat (idle) @(negedge clk_i);
      end
      $fclose(fd);
    end

    // Let the checker see the last acknowledge
    repeat (3) @(negedge clk_i);
    if (checked != num_cases) begin
      $display("Error: %0d cases were run but %0d results were checked",
               num_cases, checked);
      other_errors++;
    end

    $display("Cases %0d, results checked %0d, mismatches %0d, other errors %0d",
             num_cases, checked, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0 && num_cases > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/vipu_cases.txt
# op sew carry s1 s2 d expected mode, all hex
# mode 1 rewrites S1, S2 and D between the control write and the result read
0 0 0 7F80FF01 018001FF 00000000 80000000 0
0 2 0 FFFFFFFF 00000002 00000000 00000001 0
1 1 0 00001234 00011235 00000000 FFFFFFFF 0
1 0 0 00102030 01010101 00000000 FF0F1F2F 1
2 0 A FF1020FF 00010F00 00000000 001130FF 0
2 1 2 FFFF7FFF 00000001 00000000 00008000 0
2 2 1 12345678 11111111 00000000 2345678A 0
3 0 0 F0F0AA55 FF0F0F0F 00000000 F0000A05 0
3 2 0 12345678 0000FFFF 00000000 00005678 0
4 1 0 12340000 00005678 00000000 12345678 1
5 2 0 FFFF0000 0F0F0F0F 00000000 F0F00F0F 0
5 0 0 A5A5A5A5 FF00FF00 00000000 5AA55AA5 0
A 0 0 1003FF02 1005FF81 00000000 000F0102 0
A 1 0 0100FFFF 0100FFFF 00000000 00000001 0
B 2 0 00010000 00010003 00000005 00030005 0
B 0 0 020310FF 03041002 01FF0010 070B000E 1
6 0 0 80FF017F 7F01FF80 00000000 80FFFF80 0
8 0 0 80FF017F 7F01FF80 00000000 7F01017F 0
7 1 0 80000001 7FFFFFFF 00000000 7FFF0001 0
9 1 0 80000001 7FFFFFFF 00000000 8000FFFF 0
7 2 0 80000000 00000001 00000000 00000001 0
6 2 0 80000000 00000001 00000000 80000000 0
0 2 0 12345678 11111111 00000000 23456789 0
0 3 0 12345678 11111111 00000000 23456789 0
2 3 1 12345678 11111111 00000000 2345678A 1

//--- sources.f
hdl/vipu_pkg.sv
hdl/vipu_if.sv
hdl/vipu_simd_lane.sv
hdl/vipu_ipu.sv
hdl/vipu_wb_regs.sv
hdl/vipu_top.sv
tb/vipu_props.sv
tb/vipu_checker.sv
tb/vipu_tb.sv
